// File: src/scan_config.svh
`ifndef SCAN_CONFIG_SVH
`define SCAN_CONFIG_SVH

// 90 degrees, added to both window angles.
`define SCAN_ANGLE_OFFSET 32'sd900000

// Outputs before the first window, reso 3333 over the default window.
`define SCAN_RST_START_INDEX 16'd135
`define SCAN_RST_STOP_INDEX 16'd945
`define SCAN_RST_INDEX_NUM 16'd811

// Dividend width, one iteration per bit.
`define SCAN_DIV_STEPS 32

`endif

// File: src/scan_pkg.sv
`default_nettype none

package scan_pkg;

	// Angle in 0.0001 degree units.
	typedef logic signed [31:0] angle_t;

	// Angular step per sample.
	typedef logic [15:0] reso_t;

	// Sample index or sample count.
	typedef logic [15:0] index_t;

	typedef enum logic [1:0] {
		IDLE,
		DIV_START,
		DIV_STOP,
		COUNT
	} calc_state_t;

endpackage

`default_nettype wire

// File: src/scan_window_if.sv
`timescale 1ns/10ps
`default_nettype none

interface scan_window_if import scan_pkg::*; ();

	logic win_stb;
	angle_t win_start;
	angle_t win_stop;
	reso_t win_reso;

	modport src (
		output win_stb,
		output win_start,
		output win_stop,
		output win_reso
	);

	modport dst (
		input win_stb,
		input win_start,
		input win_stop,
		input win_reso
	);

endinterface

`default_nettype wire

// File: src/window_capture.sv
`timescale 1ns/10ps
`default_nettype none
`include "scan_config.svh"

module window_capture
	import scan_pkg::*;
(
	input wire logic i_clk_50m,
	input wire logic i_rst_n,
	input wire logic i_load,
	input wire reso_t i_angle_reso,
	input wire angle_t i_start_angle,
	input wire angle_t i_stop_angle,
	output logic o_param_error,
	scan_window_if.src o_win
);

	logic load_ok;
	logic load_bad;

	assign load_ok = i_load && (i_angle_reso != '0);
	assign load_bad = i_load && (i_angle_reso == '0);

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_win.win_stb <= 1'b0;
			o_param_error <= 1'b0;
		end else begin
			o_win.win_stb <= load_ok;
			o_param_error <= load_bad;
		end
	end

	// Window is held until the next accepted load.
	always_ff @(posedge i_clk_50m) begin
		if (load_ok) begin
			o_win.win_start <= i_start_angle + `SCAN_ANGLE_OFFSET;
			o_win.win_stop <= i_stop_angle + `SCAN_ANGLE_OFFSET;
			o_win.win_reso <= i_angle_reso;
		end
	end

	a_stb_err_excl: assert property (
		@(posedge i_clk_50m) disable iff (!i_rst_n)
		!(o_win.win_stb && o_param_error)
	) else $error("window_capture: window strobe and parameter error together");

endmodule

`default_nettype wire

// File: src/serial_divider.sv
`timescale 1ns/10ps
`default_nettype none
`include "scan_config.svh"

module serial_divider
	import scan_pkg::*;
(
	input wire logic i_clk_50m,
	input wire logic i_rst_n,
	input wire logic i_div_start,
	input wire angle_t i_dividend,
	input wire reso_t i_divisor,
	output index_t o_quotient,
	output logic o_div_done
);

	localparam int CNT_W = $clog2(`SCAN_DIV_STEPS);

	logic busy;
	logic [CNT_W-1:0] step_cnt;
	logic [`SCAN_DIV_STEPS-1:0] shift_q;
	reso_t rem_q;
	reso_t divisor_q;
	logic [16:0] rem_shift;
	logic [17:0] trial;

	// Next dividend bit enters the remainder.
	assign rem_shift = {rem_q, shift_q[`SCAN_DIV_STEPS-1]};
	assign trial = {1'b0, rem_shift} - {2'b00, divisor_q};

	// Quotient bits fill the shift register from the bottom.
	assign o_quotient = shift_q[15:0];

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy <= 1'b0;
			step_cnt <= '0;
			o_div_done <= 1'b0;
		end else begin
			o_div_done <= 1'b0;
			if (i_div_start) begin
				busy <= 1'b1;
				step_cnt <= '0;
			end else if (busy) begin
				step_cnt <= step_cnt + 1'b1;
				if (step_cnt == CNT_W'(`SCAN_DIV_STEPS - 1)) begin
					busy <= 1'b0;
					o_div_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (i_div_start) begin
			shift_q <= i_dividend;
			rem_q <= '0;
			divisor_q <= i_divisor;
		end else if (busy) begin
			// Restore on borrow.
			if (!trial[17]) begin
				rem_q <= trial[15:0];
				shift_q <= {shift_q[`SCAN_DIV_STEPS-2:0], 1'b1};
			end else begin
				rem_q <= rem_shift[15:0];
				shift_q <= {shift_q[`SCAN_DIV_STEPS-2:0], 1'b0};
			end
		end
	end

	a_divisor_nonzero: assert property (
		@(posedge i_clk_50m) disable iff (!i_rst_n)
		i_div_start |-> (i_divisor != '0)
	) else $error("serial_divider: division started with zero divisor");

	a_no_start_busy: assert property (
		@(posedge i_clk_50m) disable iff (!i_rst_n)
		i_div_start |-> !busy
	) else $error("serial_divider: start while division busy");

endmodule

`default_nettype wire

// File: src/index_calculate.sv
`timescale 1ns/10ps
`default_nettype none
`include "scan_config.svh"

module index_calculate
	import scan_pkg::*;
(
	input wire logic i_clk_50m,
	input wire logic i_rst_n,
	scan_window_if.dst i_win,
	output index_t o_start_index,
	output index_t o_stop_index,
	output index_t o_index_num,
	output logic o_index_valid
);

	calc_state_t state;
	calc_state_t state_nxt;
	logic take_window;
	logic first_done;
	logic last_done;
	logic div_start;
	logic div_done;
	angle_t dividend;
	reso_t divisor;
	angle_t stop_angle;
	index_t quotient;
	index_t start_idx;
	index_t span;

	assign take_window = (state == IDLE) && i_win.win_stb;
	assign first_done = (state == DIV_START) && div_done;
	assign last_done = (state == DIV_STOP) && div_done;

	// Distance between the two indices.
	assign span = (quotient >= start_idx) ? quotient - start_idx : start_idx - quotient;

	assign o_index_valid = (state == COUNT);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (i_win.win_stb) state_nxt = DIV_START;
			DIV_START: if (div_done) state_nxt = DIV_STOP;
			DIV_STOP: if (div_done) state_nxt = COUNT;
			COUNT: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
			div_start <= 1'b0;
			o_start_index <= `SCAN_RST_START_INDEX;
			o_stop_index <= `SCAN_RST_STOP_INDEX;
			o_index_num <= `SCAN_RST_INDEX_NUM;
		end else begin
			state <= state_nxt;
			div_start <= take_window || first_done;
			// All three outputs change as COUNT is entered.
			if (last_done) begin
				o_start_index <= start_idx;
				o_stop_index <= quotient;
				o_index_num <= span + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (take_window) begin
			dividend <= i_win.win_start;
			divisor <= i_win.win_reso;
			stop_angle <= i_win.win_stop;
		end else if (first_done) begin
			dividend <= stop_angle;
			start_idx <= quotient;
		end
	end

	serial_divider u_divider (
		.i_clk_50m (i_clk_50m),
		.i_rst_n (i_rst_n),
		.i_div_start (div_start),
		.i_dividend (dividend),
		.i_divisor (divisor),
		.o_quotient (quotient),
		.o_div_done (div_done)
	);

	a_stb_in_idle: assert property (
		@(posedge i_clk_50m) disable iff (!i_rst_n)
		i_win.win_stb |-> (state == IDLE)
	) else $error("index_calculate: window dropped during calculation");

endmodule

`default_nettype wire

// File: src/scan_index_top.sv
`timescale 1ns/10ps
`default_nettype none

module scan_index_top
	import scan_pkg::*;
(
	input wire logic i_clk_50m,
	input wire logic i_rst_n,
	input wire logic i_load,
	input wire reso_t i_angle_reso,
	input wire angle_t i_start_angle,
	input wire angle_t i_stop_angle,
	output index_t o_start_index,
	output index_t o_stop_index,
	output index_t o_index_num,
	output logic o_index_valid,
	output logic o_param_error
);

	// Offset window between the stages.
	scan_window_if win_if ();

	window_capture u_capture (
		.i_clk_50m (i_clk_50m),
		.i_rst_n (i_rst_n),
		.i_load (i_load),
		.i_angle_reso (i_angle_reso),
		.i_start_angle (i_start_angle),
		.i_stop_angle (i_stop_angle),
		.o_param_error (o_param_error),
		.o_win (win_if)
	);

	index_calculate u_calc (
		.i_clk_50m (i_clk_50m),
		.i_rst_n (i_rst_n),
		.i_win (win_if),
		.o_start_index (o_start_index),
		.o_stop_index (o_stop_index),
		.o_index_num (o_index_num),
		.o_index_valid (o_index_valid)
	);

endmodule

`default_nettype wire

// File: testbench/scan_index_checker.sv
`timescale 1ns/10ps
`default_nettype none

module scan_index_checker
	import scan_pkg::*;
(
	input wire logic i_clk_50m,
	input wire logic i_rst_n,
	input wire index_t i_start_index,
	input wire index_t i_stop_index,
	input wire index_t i_index_num,
	input wire logic i_index_valid,
	input wire logic i_param_error,
	output logic o_busy,
	output int o_fail_count
);

	localparam int VALID_LATENCY = 70;
	localparam int QUIET_CYCLES = 80;

	int pass_cnt = 0;
	int fail_cnt = 0;
	int test_id = 0;
	int test_errs = 0;
	int lat_cnt = 0;
	logic exp_err = 1'b0;
	index_t exp_start;
	index_t exp_stop;
	index_t exp_num;

	initial o_busy = 1'b0;
	assign o_fail_count = fail_cnt;

	task automatic report_fault(input string msg);
		$display("Test %0d: %s", test_id, msg);
		test_errs = test_errs + 1;
	endtask

	task automatic compare_index(input string name, input index_t exp_val, input index_t act_val);
		if (act_val !== exp_val) begin
			$display("Error: test %0d %s expected 0x%04h got 0x%04h", test_id, name, exp_val,
				act_val);
			test_errs = test_errs + 1;
		end
	endtask

	task automatic compare_outputs();
		compare_index("o_start_index", exp_start, i_start_index);
		compare_index("o_stop_index", exp_stop, i_stop_index);
		compare_index("o_index_num", exp_num, i_index_num);
	endtask

	task automatic close_test();
		if (test_errs == 0) begin
			pass_cnt = pass_cnt + 1;
			$display("Test %0d passed", test_id);
		end else begin
			fail_cnt = fail_cnt + 1;
			$display("Test %0d failed with %0d errors", test_id, test_errs);
		end
		o_busy = 1'b0;
	endtask

	// Values held from reset, before any window.
	task automatic check_reset_outputs();
		test_id = 0;
		test_errs = 0;
		exp_start = 16'd135;
		exp_stop = 16'd945;
		exp_num = 16'd811;
		compare_outputs();
		close_test();
	endtask

	task automatic expect_window(input int id, input index_t s_idx, input index_t p_idx,
		input index_t num, input logic err);
		test_id = id;
		test_errs = 0;
		exp_start = s_idx;
		exp_stop = p_idx;
		exp_num = num;
		exp_err = err;
		lat_cnt = 0;
		o_busy = 1'b1;
	endtask

	task automatic report_summary();
		$display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
	endtask

	// Cycles since the load edge.
	always @(posedge i_clk_50m) begin
		if (o_busy)
			lat_cnt = lat_cnt + 1;
	end

	always @(negedge i_clk_50m) begin
		if (i_rst_n && !o_busy) begin
			if (i_index_valid || i_param_error) begin
				$display("A strobe was seen while no test was running");
				fail_cnt = fail_cnt + 1;
			end
		end else if (i_rst_n && lat_cnt > 0) begin
			if (exp_err) begin
				if (i_param_error != (lat_cnt == 1))
					report_fault("o_param_error is not one pulse one cycle after the load");
				if (i_index_valid)
					report_fault("o_index_valid was raised for a rejected window");
				if (lat_cnt == QUIET_CYCLES) begin
					compare_outputs();
					close_test();
				end
			end else begin
				if (i_param_error)
					report_fault("o_param_error was raised for a valid window");
				if (i_index_valid) begin
					if (lat_cnt != VALID_LATENCY)
						report_fault($sformatf("o_index_valid came after %0d cycles, not %0d",
							lat_cnt, VALID_LATENCY));
					compare_outputs();
					close_test();
				end else if (lat_cnt == QUIET_CYCLES) begin
					report_fault("no o_index_valid arrived within 80 cycles");
					close_test();
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_scan_index.sv
`timescale 1ns/10ps
`default_nettype none

module tb_scan_index
	import scan_pkg::*;
();

	localparam string INPUT_FILE = "testbench/scan_window_input.txt";
	localparam int CYCLES_PER_TEST = 90;
	localparam int CYCLE_MARGIN = 200;

	logic clk_50m = 1'b0;
	logic rst_n = 1'b0;
	logic load = 1'b0;
	reso_t angle_reso = '0;
	angle_t start_angle = '0;
	angle_t stop_angle = '0;
	index_t start_index;
	index_t stop_index;
	index_t index_num;
	logic index_valid;
	logic param_error;
	logic chk_busy;
	int fail_count;
	int cycle_cnt = 0;
	int cycle_limit = CYCLE_MARGIN;

	reso_t reso_q[$];
	angle_t start_q[$];
	angle_t stop_q[$];
	index_t exp_start_q[$];
	index_t exp_stop_q[$];
	index_t exp_num_q[$];
	logic exp_err_q[$];

	always #10 clk_50m = ~clk_50m;

	always @(posedge clk_50m) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	scan_index_top DUT (
		.i_clk_50m (clk_50m),
		.i_rst_n (rst_n),
		.i_load (load),
		.i_angle_reso (angle_reso),
		.i_start_angle (start_angle),
		.i_stop_angle (stop_angle),
		.o_start_index (start_index),
		.o_stop_index (stop_index),
		.o_index_num (index_num),
		.o_index_valid (index_valid),
		.o_param_error (param_error)
	);

	scan_index_checker u_checker (
		.i_clk_50m (clk_50m),
		.i_rst_n (rst_n),
		.i_start_index (start_index),
		.i_stop_index (stop_index),
		.i_index_num (index_num),
		.i_index_valid (index_valid),
		.i_param_error (param_error),
		.o_busy (chk_busy),
		.o_fail_count (fail_count)
	);

	task automatic read_tests();
		int fd;
		int n;
		string line;
		reso_t reso;
		angle_t s_ang;
		angle_t p_ang;
		index_t s_idx;
		index_t p_idx;
		index_t num;
		logic [7:0] err;
		fd = $fopen(INPUT_FILE, "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// Lines starting with # describe the columns.
				if (n > 0 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h", reso, s_ang, p_ang, s_idx, p_idx,
						num, err);
					if (n == 7) begin
						reso_q.push_back(reso);
						start_q.push_back(s_ang);
						stop_q.push_back(p_ang);
						exp_start_q.push_back(s_idx);
						exp_stop_q.push_back(p_idx);
						exp_num_q.push_back(num);
						exp_err_q.push_back(err[0]);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_window(input int idx);
		@(negedge clk_50m);
		angle_reso = reso_q[idx];
		start_angle = start_q[idx];
		stop_angle = stop_q[idx];
		load = 1'b1;
		u_checker.expect_window(idx + 1, exp_start_q[idx], exp_stop_q[idx], exp_num_q[idx],
			exp_err_q[idx]);
		@(negedge clk_50m);
		load = 1'b0;
		wait (!chk_busy);
	endtask

	initial begin
		int gap;
		void'($urandom(2020));
		read_tests();
		if (reso_q.size() == 0) begin
			$display("No tests could be read from %s", INPUT_FILE);
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			cycle_limit = reso_q.size() * CYCLES_PER_TEST + CYCLE_MARGIN;
			repeat (16) @(posedge clk_50m);
			@(negedge clk_50m);
			rst_n = 1'b1;
			repeat (2) @(negedge clk_50m);
			u_checker.check_reset_outputs();
			for (int i = 0; i < reso_q.size(); i++) begin
				gap = $urandom_range(7, 0);
				repeat (gap) @(negedge clk_50m);
				run_window(i);
			end
			u_checker.report_summary();
			if (fail_count == 0)
				$display("ALL TESTS PASSED");
			else
				$display("SOME TESTS FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: testbench/scan_window_input.txt
# reso start stop exp_start exp_stop exp_num exp_err, all in hex
# Rejected rows (exp_err 1) expect the outputs left by the row before.
0D05 FFF92230 00225510 0087 03B1 032B 0
03E8 0006DDD0 FFFB6C20 0546 0258 02EF 0
0000 00000000 000186A0 0546 0258 02EF 1
0001 FFF24460 FFF24460 0000 0000 0001 0
0001 FFF24460 FFF24848 0000 03E8 03E9 0
FFFF FFF24460 000DBBA0 0000 001B 001C 0
0001 00000000 000DBBA0 BBA0 7740 4461 0
01F4 FFFE1DC0 0009FBF1 0611 0C24 0614 0
0000 12345678 FFFE1DC0 0611 0C24 0614 1
FFFF 000DBBA0 FFF24460 001B 0000 001C 0
0D05 FFF92230 00225510 0087 03B1 032B 0

// File: sources.f
+incdir+src
src/scan_pkg.sv
src/scan_window_if.sv
src/window_capture.sv
src/serial_divider.sv
src/index_calculate.sv
src/scan_index_top.sv
testbench/scan_index_checker.sv
testbench/tb_scan_index.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_scan_index
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
